// ==== src.f ====
+incdir+src
src/kbd_soc_pkg.sv
src/key_event_capture.sv
src/key_fifo.sv
src/rv_mini_core.sv
src/bus_decoder.sv
src/kbd_soc_top.sv
test/kbd_soc_assert.sv
test/kbd_soc_tb.sv

// ==== test/kbd_soc_tb.sv ====
`include "kbd_soc_params.svh"

module kbd_soc_tb;
    import kbd_soc_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 40;
    localparam int MAX_ROWS     = 16;

    // Row kinds and the result each row expects
    localparam int ROW_WORD     = 0;
    localparam int ROW_KEY      = 1;
    localparam int EXP_NONE     = 0;
    localparam int EXP_CONSOLE  = 1;
    localparam int EXP_LED      = 2;
    localparam int EXP_OVERFLOW = 3;
    localparam int EXP_FAULT    = 4;

    logic        clk;
    logic        reset;
    logic        key_pressed;
    key_code_t   key_code;
    rv_instr_t   instruction;
    logic [31:0] pc;
    key_code_t   console_data;
    logic        console_valid;
    logic [7:0]  led;
    logic        key_overflow;
    logic        bus_fault;

    // Program memory, 1024 words indexed by pc[11:2]
    logic [31:0] prog [0:1023];
    int          row_kind [0:MAX_ROWS-1];
    logic [31:0] row_value [0:MAX_ROWS-1];
    int          row_exp [0:MAX_ROWS-1];
    key_code_t   row_result [0:MAX_ROWS-1];
    int          num_rows = 0;
    key_code_t   console_q [$];
    logic [7:0]  led_model = 8'h00;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          checks = 0;
    int          errors = 0;

    kbd_soc_top u_kbd_soc_top (
        .clk           (clk),
        .reset         (reset),
        .key_pressed   (key_pressed),
        .key_code      (key_code),
        .instruction   (instruction),
        .pc            (pc),
        .console_data  (console_data),
        .console_valid (console_valid),
        .led           (led),
        .key_overflow  (key_overflow),
        .bus_fault     (bus_fault)
    );

    bind kbd_soc_top kbd_soc_assert u_kbd_soc_assert (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    assign instruction = prog[pc[11:2]];

    // Console bytes collected mid-cycle, where console_valid is stable
    always @(negedge clk) begin
        if (reset && console_valid) begin
            console_q.push_back(console_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Unused opcode tagged with its word index, runs as a no-op
    function automatic logic [31:0] fill_word(input int index);
        return {index[24:0], 7'b0001111};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_sb(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
    endfunction

    task automatic add_row(input int kind, input logic [31:0] value, input int exp,
                           input key_code_t result);
        row_kind[num_rows]   = kind;
        row_value[num_rows]  = value;
        row_exp[num_rows]    = exp;
        row_result[num_rows] = result;
        num_rows++;
    endtask

    task automatic check_console(input key_code_t got, input key_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: console_data = 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: led = 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: pc = 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_no_console();
        checks++;
        if (console_q.size() != 0) begin
            errors++;
            $display("Console wrote %0d byte(s) where none was due", console_q.size());
            console_q.delete();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // The word goes in at the fetch address, so it runs once the core is free
    task automatic run_word(input logic [31:0] word);
        logic [31:0] addr;
        addr = pc;
        prog[addr[11:2]] = word;
        do begin
            next_cycle();
        end while (pc == addr);
        // An executed word moves pc on by one word
        check_pc(pc, addr + 32'd4);
    endtask

    // Four cycles high, then four low so the next rise is seen
    task automatic press_key(input key_code_t code);
        key_code    = code;
        key_pressed = 1'b1;
        repeat (4) next_cycle();
        key_pressed = 1'b0;
        repeat (4) next_cycle();
    endtask

    task automatic check_row(input int i);
        key_code_t got;
        case (row_exp[i])
            EXP_CONSOLE: begin
                while (console_q.size() == 0) begin
                    next_cycle();
                end
                got = console_q.pop_front();
                check_console(got, row_result[i]);
            end
            EXP_LED: begin
                next_cycle();
                check_led(led, row_result[i]);
                led_model = row_result[i];
            end
            EXP_OVERFLOW: begin
                check_flag("key_overflow", key_overflow, row_result[i][0]);
                check_no_console();
            end
            EXP_FAULT: begin
                next_cycle();
                check_flag("bus_fault", bus_fault, row_result[i][0]);
                check_led(led, led_model);
                check_no_console();
            end
            default: begin
            end
        endcase
    endtask

    task automatic build_table();
        key_code_t   keys [0:4];
        logic [19:0] upper;
        logic [11:0] led_off;
        logic [11:0] ctrl_off;
        keys     = '{8'h48, 8'h45, 8'h4c, 8'h50, 8'h21};
        upper    = 20'(`KBD_CONSOLE_ADDR >> 12);
        led_off  = 12'(`KBD_LED_ADDR - `KBD_CONSOLE_ADDR);
        ctrl_off = 12'(`KBD_CTRL_ADDR - `KBD_CONSOLE_ADDR);
        // x1 is the sign-extended console base, only its low 32 bits decode
        add_row(ROW_WORD, enc_lui(5'd1, upper), EXP_NONE, 8'h00);
        add_row(ROW_WORD, enc_addi(5'd2, 5'd0, 12'h05a), EXP_NONE, 8'h00);
        add_row(ROW_WORD, enc_sb(5'd2, 5'd1, led_off), EXP_LED, 8'h5a);
        add_row(ROW_WORD, enc_sb(5'd2, 5'd1, 12'h000), EXP_CONSOLE, 8'h5a);
        // Queue fills at four, the fifth key is dropped
        for (int k = 0; k < 5; k++) begin
            add_row(ROW_KEY, {24'h0, keys[k]}, EXP_OVERFLOW, (k == 4) ? 8'h01 : 8'h00);
        end
        add_row(ROW_WORD, enc_addi(5'd3, 5'd0, 12'h001), EXP_NONE, 8'h00);
        add_row(ROW_WORD, enc_sb(5'd3, 5'd1, ctrl_off), EXP_CONSOLE, keys[0]);
        for (int k = 1; k < 4; k++) begin
            add_row(ROW_WORD, enc_addi(5'd0, 5'd0, 12'h000), EXP_CONSOLE, keys[k]);
        end
        // Offset 0x40 lies outside the map
        add_row(ROW_WORD, enc_sb(5'd2, 5'd1, 12'h040), EXP_FAULT, 8'h01);
        cycle_limit = num_rows * ROW_CYCLES;
    endtask

    initial begin
        int errors_before;
        reset       = 1'b0;
        key_pressed = 1'b0;
        key_code    = '0;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = fill_word(i);
        end
        build_table();
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b1;
        check_pc(pc, 32'd0);
        check_led(led, 8'h00);
        check_flag("console_valid", console_valid, 1'b0);
        check_flag("key_overflow", key_overflow, 1'b0);
        check_flag("bus_fault", bus_fault, 1'b0);
        $display("test 0 (reset values) done, %s", (errors == 0) ? "ok" : "mismatch");
        for (int i = 0; i < num_rows; i++) begin
            errors_before = errors;
            if (row_kind[i] == ROW_KEY) begin
                press_key(row_value[i][7:0]);
            end else begin
                run_word(row_value[i]);
            end
            check_row(i);
            $display("test %0d done, %s", i + 1, (errors == errors_before) ? "ok" : "mismatch");
        end
        repeat (4) next_cycle();
        check_no_console();
        errors += u_kbd_soc_top.u_kbd_soc_assert.failures;
        $display("tests %0d, checks %0d, errors %0d", num_rows + 1, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== test/kbd_soc_assert.sv ====
module kbd_soc_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   push,
    input logic                   full,
    input logic                   pop,
    input logic                   empty,
    input kbd_soc_pkg::key_code_t rd_code,
    input kbd_soc_pkg::key_code_t console_data,
    input logic                   console_valid,
    input logic                   bus_fault,
    input logic                   bus_write_enable
);

    int failures = 0;

    push_not_full: assert property (@(posedge clk) disable iff (!reset) push |-> !full)
        else begin
            failures++;
            $error("push while the key queue is full");
        end

    // A pop takes a queued entry, which reaches the console two cycles on
    pop_not_empty: assert property (@(posedge clk) disable iff (!reset)
                                    pop |-> !empty ##2
                                    (console_valid && console_data == $past(rd_code, 2)))
        else begin
            failures++;
            $error("pop without a queued key reaching the console");
        end

    // A write goes to one target only
    console_or_fault: assert property (@(posedge clk) disable iff (!reset)
                                       !(console_valid && bus_fault))
        else begin
            failures++;
            $error("console_valid and bus_fault high together");
        end

    // Each serviced key gives a strobe in the next cycle
    pop_strobe: assert property (@(posedge clk) disable iff (!reset) pop |=> bus_write_enable)
        else begin
            failures++;
            $error("no bus write after a key pop");
        end

endmodule

// ==== src/kbd_soc_top.sv ====
module kbd_soc_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   key_pressed,
    input  kbd_soc_pkg::key_code_t key_code,
    input  kbd_soc_pkg::rv_instr_t instruction,
    output logic [31:0]            pc,
    output kbd_soc_pkg::key_code_t console_data,
    output logic                   console_valid,
    output logic [7:0]             led,
    output logic                   key_overflow,
    output logic                   bus_fault
);
    import kbd_soc_pkg::*;

    // Capture to queue
    logic      push;
    key_code_t push_code;
    logic      full;

    // Queue to core
    key_code_t rd_code;
    logic      empty;
    logic      pop;

    // Core write bus
    bus_addr_t bus_address;
    bus_data_t bus_write_data;
    logic      bus_write_enable;
    logic      irq_enable;

    key_event_capture u_key_event_capture (
        .clk          (clk),
        .reset        (reset),
        .key_pressed  (key_pressed),
        .key_code     (key_code),
        .full         (full),
        .push         (push),
        .push_code    (push_code),
        .key_overflow (key_overflow)
    );

    key_fifo u_key_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_code (push_code),
        .pop       (pop),
        .rd_code   (rd_code),
        .empty     (empty),
        .full      (full)
    );

    rv_mini_core u_rv_mini_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .rd_code          (rd_code),
        .empty            (empty),
        .irq_enable       (irq_enable),
        .pc               (pc),
        .pop              (pop),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable)
    );

    bus_decoder u_bus_decoder (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .console_data     (console_data),
        .console_valid    (console_valid),
        .led              (led),
        .irq_enable       (irq_enable),
        .bus_fault        (bus_fault)
    );

endmodule

// ==== src/bus_decoder.sv ====
`include "kbd_soc_params.svh"

module bus_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  kbd_soc_pkg::bus_addr_t bus_address,
    input  kbd_soc_pkg::bus_data_t bus_write_data,
    input  logic                   bus_write_enable,
    output kbd_soc_pkg::key_code_t console_data,
    output logic                   console_valid,
    output logic [7:0]             led,
    output logic                   irq_enable,
    output logic                   bus_fault
);

    logic [`KBD_DECODE_WIDTH-1:0] low_addr;
    logic                         sel_console;
    logic                         sel_led;
    logic                         sel_ctrl;

    // Upper address bits are don't care
    assign low_addr    = bus_address[`KBD_DECODE_WIDTH-1:0];
    assign sel_console = (low_addr == `KBD_CONSOLE_ADDR);
    assign sel_led     = (low_addr == `KBD_LED_ADDR);
    assign sel_ctrl    = (low_addr == `KBD_CTRL_ADDR);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            console_valid <= 1'b0;
            led           <= 8'h00;
            irq_enable    <= 1'b0;
            bus_fault     <= 1'b0;
        end else begin
            console_valid <= bus_write_enable && sel_console;
            bus_fault     <= bus_write_enable && !(sel_console || sel_led || sel_ctrl);
            if (bus_write_enable && sel_led) begin
                led <= bus_write_data[7:0];
            end
            // Control bit 0 gates key interrupts
            if (bus_write_enable && sel_ctrl) begin
                irq_enable <= bus_write_data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_write_enable && sel_console) begin
            console_data <= bus_write_data[`KBD_CODE_WIDTH-1:0];
        end
    end

endmodule

// ==== src/rv_mini_core.sv ====
`include "kbd_soc_params.svh"

module rv_mini_core (
    input  logic                   clk,
    input  logic                   reset,
    input  kbd_soc_pkg::rv_instr_t instruction,
    input  kbd_soc_pkg::key_code_t rd_code,
    input  logic                   empty,
    input  logic                   irq_enable,
    output logic [31:0]            pc,
    output logic                   pop,
    output kbd_soc_pkg::bus_addr_t bus_address,
    output kbd_soc_pkg::bus_data_t bus_write_data,
    output logic                   bus_write_enable
);
    import kbd_soc_pkg::*;

    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_SB   = 3'b000;

    bus_data_t regs [0:`KBD_NUM_REGS-1];

    logic      service;
    logic      is_lui;
    logic      is_addi;
    logic      is_sb;
    logic      wr_en;
    logic [4:0] wr_rd;
    bus_data_t wr_data;
    bus_data_t imm_u;
    bus_data_t imm_i;
    bus_data_t imm_s;
    bus_data_t addi_src;
    bus_data_t sb_base;
    bus_data_t sb_src;

    // A pending key wins over the instruction at pc
    assign service = irq_enable && !empty;
    assign pop     = service;

    // Sign-extended immediates for each format
    assign imm_u = {{(`KBD_XLEN-32){instruction.u_view.imm20[19]}},
                    instruction.u_view.imm20, 12'b0};
    assign imm_i = {{(`KBD_XLEN-12){instruction.i_view.imm12[11]}},
                    instruction.i_view.imm12};
    assign imm_s = {{(`KBD_XLEN-12){instruction.s_view.imm_hi[6]}},
                    instruction.s_view.imm_hi, instruction.s_view.imm_lo};

    // x0 always reads as zero
    assign addi_src = (instruction.i_view.rs1 == 5'd0) ? '0 : regs[instruction.i_view.rs1];
    assign sb_base  = (instruction.s_view.rs1 == 5'd0) ? '0 : regs[instruction.s_view.rs1];
    assign sb_src   = (instruction.s_view.rs2 == 5'd0) ? '0 : regs[instruction.s_view.rs2];

    always_comb begin
        is_lui  = 1'b0;
        is_addi = 1'b0;
        is_sb   = 1'b0;
        case (instruction.u_view.opcode)
            OPC_LUI: begin
                is_lui = 1'b1;
            end
            OPC_OP_IMM: begin
                is_addi = (instruction.i_view.funct3 == F3_ADDI);
            end
            OPC_STORE: begin
                is_sb = (instruction.s_view.funct3 == F3_SB);
            end
            default: begin
                // Unsupported opcodes fall through as no-ops
                is_lui = 1'b0;
            end
        endcase
    end

    // Register write port, only in an instruction cycle
    always_comb begin
        wr_en   = !service && (is_lui || is_addi);
        wr_rd   = instruction.u_view.rd;
        wr_data = is_lui ? imm_u : (addi_src + imm_i);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc               <= 32'd0;
            bus_write_enable <= 1'b0;
        end else if (service) begin
            // pc holds so the deferred instruction runs next
            bus_write_enable <= 1'b1;
        end else begin
            pc               <= pc + 32'd4;
            bus_write_enable <= is_sb;
        end
    end

    // Bus payload keeps its last value between strobes
    always_ff @(posedge clk) begin
        if (service) begin
            bus_address    <= bus_addr_t'(`KBD_CONSOLE_ADDR);
            bus_write_data <= bus_data_t'(rd_code);
        end else if (is_sb) begin
            bus_address    <= sb_base + imm_s;
            bus_write_data <= bus_data_t'(sb_src[7:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wr_rd != 5'd0)) begin
            regs[wr_rd] <= wr_data;
        end
    end

endmodule

// ==== src/key_fifo.sv ====
`include "kbd_soc_params.svh"

module key_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  kbd_soc_pkg::key_code_t push_code,
    input  logic                   pop,
    output kbd_soc_pkg::key_code_t rd_code,
    output logic                   empty,
    output logic                   full
);
    import kbd_soc_pkg::*;

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    key_code_t        mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Push while full is refused, pop while empty is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Oldest entry falls through to the output
    assign rd_code = mem[rd_ptr];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

endmodule

// ==== src/key_event_capture.sv ====
module key_event_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  key_pressed,
    input  kbd_soc_pkg::key_code_t key_code,
    input  logic                  full,
    output logic                  push,
    output kbd_soc_pkg::key_code_t push_code,
    output logic                  key_overflow
);

    logic pressed_meta;
    logic pressed_sync;
    logic pressed_prev;
    logic pressed_rise;

    // Level is already stable in pressed_sync, so the edge is a plain compare
    assign pressed_rise = pressed_sync && !pressed_prev;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pressed_meta <= 1'b0;
            pressed_sync <= 1'b0;
            pressed_prev <= 1'b0;
        end else begin
            pressed_meta <= key_pressed;
            pressed_sync <= pressed_meta;
            pressed_prev <= pressed_sync;
        end
    end

    // One push per key press, dropped when the queue has no room
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            push         <= 1'b0;
            key_overflow <= 1'b0;
        end else begin
            push <= pressed_rise && !full;
            if (pressed_rise && full) begin
                key_overflow <= 1'b1;
            end
        end
    end

    // Code is held by the keyboard side until the push goes out
    always_ff @(posedge clk) begin
        if (pressed_rise) begin
            push_code <= key_code;
        end
    end

endmodule

// ==== src/kbd_soc_pkg.sv ====
`include "kbd_soc_params.svh"

package kbd_soc_pkg;

    // ASCII key code as delivered by the keyboard front end
    typedef logic [`KBD_CODE_WIDTH-1:0] key_code_t;

    // Write bus address and data
    typedef logic [`KBD_XLEN-1:0] bus_addr_t;
    typedef logic [`KBD_XLEN-1:0] bus_data_t;

    // Opcodes the core executes, everything else is a no-op
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011
    } rv_opcode_e;

    // U-type layout
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_view_t;

    // I-type layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    // S-type layout, immediate split around the register fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_s_view_t;

    typedef union packed {
        rv_u_view_t u_view;
        rv_i_view_t i_view;
        rv_s_view_t s_view;
    } rv_instr_t;

endpackage

// ==== src/kbd_soc_params.svh ====
`ifndef KBD_SOC_PARAMS_SVH
`define KBD_SOC_PARAMS_SVH

// Write bus map, compared on the low address bits only
`define KBD_CONSOLE_ADDR 32'h8000_0000
`define KBD_LED_ADDR 32'h8000_0020
`define KBD_CTRL_ADDR 32'h8000_0030

// Number of address bits the decoder looks at
`define KBD_DECODE_WIDTH 32

// Key queue depth, a power of two from 2 to 16
`define KBD_FIFO_DEPTH 4

// Core register file
`define KBD_NUM_REGS 32

// Datapath widths
`define KBD_XLEN 64
`define KBD_CODE_WIDTH 8

`endif
